// ==== design/cpu_ex.sv ====
`timescale 1ns/10ps

module cpu_ex import mips_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  op_t       op,
	input  word_t     opa,
	input  word_t     opb,
	input  logic      we,
	input  reg_addr_t waddr,
	output word_t     result,
	output logic      wb_we,
	output reg_addr_t wb_waddr,
	output word_t     wb_wdata
);

logic slt_bit;

assign slt_bit = $signed(opa) < $signed(opb);

always_comb begin
	case (op)
		OP_ADDU, OP_ADDIU: result = opa + opb;
		OP_SUBU:           result = opa - opb;
		OP_AND:            result = opa & opb;
		OP_OR:             result = opa | opb;
		OP_XOR:            result = opa ^ opb;
		OP_SLT:            result = {31'b0, slt_bit};
		// Immediate already shifted in decode
		OP_LUI:            result = opb;
		default:           result = '0;
	endcase
end

// EX/WB register
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		wb_we <= 1'b0;
	end else begin
		wb_we <= we;
	end
end

always_ff @(posedge clk) begin
	wb_waddr <= waddr;
	wb_wdata <= result;
end

// Decode never flags a write to r0
a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
	wb_we |-> wb_waddr != '0)
	else $error("write-back to r0 requested");

endmodule

// ==== design/cpu_id.sv ====
`timescale 1ns/10ps

module cpu_id import mips_pkg::*; (
	input  word_t     inst,
	output reg_addr_t raddr1,
	output reg_addr_t raddr2,
	input  word_t     rdata1,
	input  word_t     rdata2,
	input  logic      ex_we_a,
	input  reg_addr_t ex_waddr_a,
	input  word_t     ex_wdata_a,
	input  logic      ex_we_b,
	input  reg_addr_t ex_waddr_b,
	input  word_t     ex_wdata_b,
	input  logic      wb_we_a,
	input  reg_addr_t wb_waddr_a,
	input  word_t     wb_wdata_a,
	input  logic      wb_we_b,
	input  reg_addr_t wb_waddr_b,
	input  word_t     wb_wdata_b,
	output op_t       op,
	output word_t     opa,
	output word_t     opb,
	output logic      we,
	output reg_addr_t waddr,
	output logic      reads_rt
);

logic [5:0]  opcode;
logic [5:0]  funct;
reg_addr_t   rs;
reg_addr_t   rt;
reg_addr_t   rd;
logic [15:0] imm;
word_t       imm_ext;
logic        reads_rs;

assign opcode = inst[OPCODE_MSB:OPCODE_LSB];
assign funct  = inst[FUNCT_MSB:FUNCT_LSB];
assign rs     = inst[RS_MSB:RS_LSB];
assign rt     = inst[RT_MSB:RT_LSB];
assign rd     = inst[RD_MSB:RD_LSB];
assign imm    = inst[IMM_MSB:IMM_LSB];

// Youngest producer first, beta before alpha within a stage
function automatic word_t forward(input reg_addr_t addr, input word_t rf_data);
	if (addr == '0) return '0;
	if (ex_we_b && ex_waddr_b == addr) return ex_wdata_b;
	if (ex_we_a && ex_waddr_a == addr) return ex_wdata_a;
	if (wb_we_b && wb_waddr_b == addr) return wb_wdata_b;
	if (wb_we_a && wb_waddr_a == addr) return wb_wdata_a;
	return rf_data;
endfunction

always_comb begin
	op       = OP_NOP;
	waddr    = '0;
	reads_rs = 1'b0;
	reads_rt = 1'b0;
	imm_ext  = '0;
	case (opcode)
		OPC_SPECIAL: begin
			reads_rs = 1'b1;
			reads_rt = 1'b1;
			waddr    = rd;
			case (funct)
				FUNCT_ADDU: op = OP_ADDU;
				FUNCT_SUBU: op = OP_SUBU;
				FUNCT_AND:  op = OP_AND;
				FUNCT_OR:   op = OP_OR;
				FUNCT_XOR:  op = OP_XOR;
				FUNCT_SLT:  op = OP_SLT;
				default:    op = OP_NOP;
			endcase
		end
		OPC_ADDIU: begin
			op       = OP_ADDIU;
			reads_rs = 1'b1;
			waddr    = rt;
			imm_ext  = {{16{imm[15]}}, imm};
		end
		OPC_LUI: begin
			op      = OP_LUI;
			waddr   = rt;
			imm_ext = {imm, 16'h0000};
		end
		default: op = OP_NOP;
	endcase
	// Unknown encodings read and write nothing
	if (op == OP_NOP) begin
		reads_rs = 1'b0;
		reads_rt = 1'b0;
		waddr    = '0;
	end
end

assign raddr1 = reads_rs ? rs : '0;
assign raddr2 = rt;
assign we     = (op != OP_NOP) && (waddr != '0);

always_comb begin
	opa = forward(raddr1, rdata1);
	opb = reads_rt ? forward(raddr2, rdata2) : imm_ext;
end

endmodule

// ==== design/mips_pkg.sv ====
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// Decoded operations, one ALU function each
	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_ADDIU,
		OP_LUI
	} op_t;

	// Instruction field positions
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;
	localparam int RS_MSB     = 25;
	localparam int RS_LSB     = 21;
	localparam int RT_MSB     = 20;
	localparam int RT_LSB     = 16;
	localparam int RD_MSB     = 15;
	localparam int RD_LSB     = 11;
	localparam int IMM_MSB    = 15;
	localparam int IMM_LSB    = 0;
	localparam int FUNCT_MSB  = 5;
	localparam int FUNCT_LSB  = 0;

	// Primary opcodes
	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_LUI     = 6'b001111;

	// SPECIAL function codes
	localparam logic [5:0] FUNCT_ADDU = 6'b100001;
	localparam logic [5:0] FUNCT_SUBU = 6'b100011;
	localparam logic [5:0] FUNCT_AND  = 6'b100100;
	localparam logic [5:0] FUNCT_OR   = 6'b100101;
	localparam logic [5:0] FUNCT_XOR  = 6'b100110;
	localparam logic [5:0] FUNCT_SLT  = 6'b101010;

	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// ==== design/reg_pc.sv ====
`timescale 1ns/10ps

module reg_pc import mips_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  inst2_taken,
	output word_t pc
);

word_t pc_step;

// Skip both words when the pair issued together
assign pc_step = inst2_taken ? 32'd8 : 32'd4;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pc <= RESET_PC;
	end else begin
		pc <= pc + pc_step;
	end
end

endmodule

// ==== design/regs.sv ====
`timescale 1ns/10ps

module regs import mips_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	input  reg_addr_t raddr3,
	input  reg_addr_t raddr4,
	output word_t     rdata1,
	output word_t     rdata2,
	output word_t     rdata3,
	output word_t     rdata4,
	input  logic      we1,
	input  reg_addr_t waddr1,
	input  word_t     wdata1,
	input  logic      we2,
	input  reg_addr_t waddr2,
	input  word_t     wdata2
);

// r0 has no storage
word_t gpr [1:31];

always_ff @(posedge clk) begin
	if (we1 && waddr1 != '0) begin
		gpr[waddr1] <= wdata1;
	end
	if (we2 && waddr2 != '0) begin
		gpr[waddr2] <= wdata2;
	end
end

assign rdata1 = (raddr1 == '0) ? '0 : gpr[raddr1];
assign rdata2 = (raddr2 == '0) ? '0 : gpr[raddr2];
assign rdata3 = (raddr3 == '0) ? '0 : gpr[raddr3];
assign rdata4 = (raddr4 == '0) ? '0 : gpr[raddr4];

// Pairing keeps the two pipes off the same destination
a_no_dual_write: assert property (@(posedge clk) disable iff (!arst_n)
	!(we1 && we2 && waddr1 == waddr2 && waddr1 != '0))
	else $error("both write ports target r%0d", waddr1);

endmodule

// ==== design/superscalar_ctrl.sv ====
`timescale 1ns/10ps

module superscalar_ctrl import mips_pkg::*; (
	input  logic      we_a,
	input  reg_addr_t waddr_a,
	input  reg_addr_t raddr1_b,
	input  reg_addr_t raddr2_b,
	input  logic      reads_rt_b,
	input  logic      we_b,
	input  reg_addr_t waddr_b,
	output logic      inst2_taken
);

logic alpha_writes;
logic raw_rs;
logic raw_rt;
logic waw;

assign alpha_writes = we_a && (waddr_a != '0);

// raddr1_b is already zero when beta has no rs operand
assign raw_rs = (raddr1_b == waddr_a);
assign raw_rt = reads_rt_b && (raddr2_b == waddr_a);

// Same destination in one pair
assign waw = we_b && (waddr_b == waddr_a);

assign inst2_taken = !(alpha_writes && (raw_rs || raw_rt || waw));

endmodule

// ==== design/trivial_mips.sv ====
`timescale 1ns/10ps

module trivial_mips import mips_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	output word_t     inst_addr,
	input  word_t     inst_rdata1,
	input  word_t     inst_rdata2,
	output logic      wb_we_a,
	output reg_addr_t wb_waddr_a,
	output word_t     wb_wdata_a,
	output logic      wb_we_b,
	output reg_addr_t wb_waddr_b,
	output word_t     wb_wdata_b
);

word_t pc;
logic  inst2_taken;

reg_addr_t reg_raddr1, reg_raddr2, reg_raddr3, reg_raddr4;
word_t     reg_rdata1, reg_rdata2, reg_rdata3, reg_rdata4;

op_t       id_op_a, id_op_b;
word_t     id_opa_a, id_opb_a, id_opa_b, id_opb_b;
logic      id_we_a, id_we_b;
reg_addr_t id_waddr_a, id_waddr_b;
logic      id_reads_rt_b;

op_t       idex_op_a, idex_op_b;
word_t     idex_opa_a, idex_opb_a, idex_opa_b, idex_opb_b;
logic      idex_we_a, idex_we_b;
reg_addr_t idex_waddr_a, idex_waddr_b;

word_t ex_result_a, ex_result_b;

reg_pc pc_instance(
	.clk,
	.arst_n,
	.inst2_taken,
	.pc
);

assign inst_addr = pc;

// Write ports fed straight from EX/WB
regs general_regs_instance(
	.clk,
	.arst_n,
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.raddr3(reg_raddr3),
	.raddr4(reg_raddr4),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.rdata3(reg_rdata3),
	.rdata4(reg_rdata4),
	.we1(wb_we_a),
	.waddr1(wb_waddr_a),
	.wdata1(wb_wdata_a),
	.we2(wb_we_b),
	.waddr2(wb_waddr_b),
	.wdata2(wb_wdata_b)
);

cpu_id stage_id_a(
	.inst(inst_rdata1),
	.raddr1(reg_raddr1),
	.raddr2(reg_raddr2),
	.rdata1(reg_rdata1),
	.rdata2(reg_rdata2),
	.ex_we_a(idex_we_a),
	.ex_waddr_a(idex_waddr_a),
	.ex_wdata_a(ex_result_a),
	.ex_we_b(idex_we_b),
	.ex_waddr_b(idex_waddr_b),
	.ex_wdata_b(ex_result_b),
	.wb_we_a,
	.wb_waddr_a,
	.wb_wdata_a,
	.wb_we_b,
	.wb_waddr_b,
	.wb_wdata_b,
	.op(id_op_a),
	.opa(id_opa_a),
	.opb(id_opb_a),
	.we(id_we_a),
	.waddr(id_waddr_a),
	.reads_rt()
);

cpu_id stage_id_b(
	.inst(inst_rdata2),
	.raddr1(reg_raddr3),
	.raddr2(reg_raddr4),
	.rdata1(reg_rdata3),
	.rdata2(reg_rdata4),
	.ex_we_a(idex_we_a),
	.ex_waddr_a(idex_waddr_a),
	.ex_wdata_a(ex_result_a),
	.ex_we_b(idex_we_b),
	.ex_waddr_b(idex_waddr_b),
	.ex_wdata_b(ex_result_b),
	.wb_we_a,
	.wb_waddr_a,
	.wb_wdata_a,
	.wb_we_b,
	.wb_waddr_b,
	.wb_wdata_b,
	.op(id_op_b),
	.opa(id_opa_b),
	.opb(id_opb_b),
	.we(id_we_b),
	.waddr(id_waddr_b),
	.reads_rt(id_reads_rt_b)
);

superscalar_ctrl superscalar_ctrl_instance(
	.we_a(id_we_a),
	.waddr_a(id_waddr_a),
	.raddr1_b(reg_raddr3),
	.raddr2_b(reg_raddr4),
	.reads_rt_b(id_reads_rt_b),
	.we_b(id_we_b),
	.waddr_b(id_waddr_b),
	.inst2_taken
);

// ID/EX registers
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		idex_op_a <= OP_NOP;
		idex_we_a <= 1'b0;
		idex_op_b <= OP_NOP;
		idex_we_b <= 1'b0;
	end else begin
		idex_op_a <= id_op_a;
		idex_we_a <= id_we_a;
		// A held-back beta leaves a bubble, it is refetched as alpha
		idex_op_b <= inst2_taken ? id_op_b : OP_NOP;
		idex_we_b <= inst2_taken && id_we_b;
	end
end

always_ff @(posedge clk) begin
	idex_opa_a   <= id_opa_a;
	idex_opb_a   <= id_opb_a;
	idex_waddr_a <= id_waddr_a;
	idex_opa_b   <= id_opa_b;
	idex_opb_b   <= id_opb_b;
	idex_waddr_b <= id_waddr_b;
end

cpu_ex stage_ex_a(
	.clk,
	.arst_n,
	.op(idex_op_a),
	.opa(idex_opa_a),
	.opb(idex_opb_a),
	.we(idex_we_a),
	.waddr(idex_waddr_a),
	.result(ex_result_a),
	.wb_we(wb_we_a),
	.wb_waddr(wb_waddr_a),
	.wb_wdata(wb_wdata_a)
);

cpu_ex stage_ex_b(
	.clk,
	.arst_n,
	.op(idex_op_b),
	.opa(idex_opa_b),
	.opb(idex_opb_b),
	.we(idex_we_b),
	.waddr(idex_waddr_b),
	.result(ex_result_b),
	.wb_we(wb_we_b),
	.wb_waddr(wb_waddr_b),
	.wb_wdata(wb_wdata_b)
);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_trivial_mips \
	-f tb.f \
	-o tb_sim

# Pass only when the pass line shows up in the output
./obj_dir/tb_sim | tee /dev/stderr | grep -x "Done: no errors" > /dev/null

// ==== tb.f ====
design/mips_pkg.sv
design/reg_pc.sv
design/regs.sv
design/cpu_id.sv
design/superscalar_ctrl.sv
design/cpu_ex.sv
design/trivial_mips.sv
verif/tb_clock.sv
verif/tb_trivial_mips.sv

// ==== verif/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
	input  logic reset_req,
	output logic clk,
	output logic arst_n
);

// 4 ns period
initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

// Reset held for 8 cycles, released on a falling edge
initial begin
	arst_n = 1'b0;
	repeat (8) @(negedge clk);
	arst_n = 1'b1;
	forever begin
		@(posedge reset_req);
		arst_n = 1'b0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
	end
end

endmodule

// ==== verif/tb_trivial_mips.sv ====
`timescale 1ns/10ps

module tb_trivial_mips import mips_pkg::*; ();

localparam int CLK_PERIOD_NS = 4;
localparam int RESET_CYCLES  = 8;
localparam int DRAIN_LIMIT   = 300;
localparam int TAIL_CYCLES   = 4;
localparam int TEST_COUNT    = 6;
localparam int MEM_WORDS     = 256;
localparam int WATCHDOG_NS   =
	TEST_COUNT * (RESET_CYCLES + DRAIN_LIMIT + TAIL_CYCLES + 4) * CLK_PERIOD_NS + 200;

logic      clk;
logic      arst_n;
logic      reset_req;
word_t     inst_addr;
word_t     pair_addr;
word_t     inst_rdata1;
word_t     inst_rdata2;
logic      wb_we_a;
reg_addr_t wb_waddr_a;
word_t     wb_wdata_a;
logic      wb_we_b;
reg_addr_t wb_waddr_b;
word_t     wb_wdata_b;

word_t     imem [0:MEM_WORDS-1];
word_t     prog[$];
word_t     model_rf [0:31];
reg_addr_t exp_reg[$];
word_t     exp_val[$];
word_t     lfsr = 32'hed88;
int        mismatches = 0;
int        other_errors = 0;

tb_clock clock_gen (
	.reset_req,
	.clk,
	.arst_n
);

trivial_mips uut (
	.clk,
	.arst_n,
	.inst_addr,
	.inst_rdata1,
	.inst_rdata2,
	.wb_we_a,
	.wb_waddr_a,
	.wb_wdata_a,
	.wb_we_b,
	.wb_waddr_b,
	.wb_wdata_b
);

// Words past the end of memory read as NOP
assign pair_addr   = inst_addr + 32'd4;
assign inst_rdata1 = (inst_addr[31:10] == '0) ? imem[inst_addr[9:2]] : '0;
assign inst_rdata2 = (pair_addr[31:10] == '0) ? imem[pair_addr[9:2]] : '0;

function automatic logic lfsr_next_bit();
	logic out_bit;
	out_bit = lfsr[0];
	lfsr = lfsr >> 1;
	if (out_bit) begin
		lfsr = lfsr ^ 32'h8020_0003;
	end
	return out_bit;
endfunction

function automatic word_t rand_bits(input int n);
	word_t value;
	value = '0;
	for (int i = 0; i < n; i++) begin
		value = {value[30:0], lfsr_next_bit()};
	end
	return value;
endfunction

function automatic word_t encode_rtype(input logic [5:0] funct, input int rd, input int rs,
		input int rt);
	return {OPC_SPECIAL, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd), 5'b00000, funct};
endfunction

function automatic word_t encode_itype(input logic [5:0] opc, input int rt, input int rs,
		input logic [15:0] imm);
	return {opc, reg_addr_t'(rs), reg_addr_t'(rt), imm};
endfunction

function automatic logic [5:0] funct_code(input int k);
	case (k)
		0:       return FUNCT_ADDU;
		1:       return FUNCT_SUBU;
		2:       return FUNCT_AND;
		3:       return FUNCT_OR;
		4:       return FUNCT_XOR;
		default: return FUNCT_SLT;
	endcase
endfunction

// LUI then ADDIU with the low half sign-extended
task automatic load_const(input int rt, input word_t value);
	prog.push_back(encode_itype(OPC_LUI, rt, 0, value[31:16]));
	prog.push_back(encode_itype(OPC_ADDIU, rt, rt, value[15:0]));
endtask

// In-order reference execution of one instruction
function automatic void model_exec(input word_t inst);
	logic [5:0] opc;
	logic [5:0] funct;
	reg_addr_t  dest;
	word_t      a;
	word_t      b;
	word_t      res;
	logic       valid;
	opc   = inst[OPCODE_MSB:OPCODE_LSB];
	funct = inst[FUNCT_MSB:FUNCT_LSB];
	a     = model_rf[inst[RS_MSB:RS_LSB]];
	b     = model_rf[inst[RT_MSB:RT_LSB]];
	dest  = inst[RD_MSB:RD_LSB];
	res   = '0;
	valid = 1'b1;
	case (opc)
		OPC_SPECIAL: begin
			case (funct)
				FUNCT_ADDU: res = a + b;
				FUNCT_SUBU: res = a - b;
				FUNCT_AND:  res = a & b;
				FUNCT_OR:   res = a | b;
				FUNCT_XOR:  res = a ^ b;
				FUNCT_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default:    valid = 1'b0;
			endcase
		end
		OPC_ADDIU: begin
			dest = inst[RT_MSB:RT_LSB];
			res  = a + {{16{inst[15]}}, inst[15:0]};
		end
		OPC_LUI: begin
			dest = inst[RT_MSB:RT_LSB];
			res  = {inst[15:0], 16'h0000};
		end
		default: valid = 1'b0;
	endcase
	if (valid && dest != '0) begin
		model_rf[dest] = res;
		exp_reg.push_back(dest);
		exp_val.push_back(res);
	end
endfunction

task automatic compare_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("mismatch %s: got %h expected %h", name, got, exp);
		mismatches++;
	end
endtask

task automatic compare_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
	if (got !== exp) begin
		$display("mismatch %s: got %h expected %h", name, got, exp);
		mismatches++;
	end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("mismatch %s: got %h expected %h", name, got, exp);
		mismatches++;
	end
endtask

task automatic match_write_back(input string sfx, input reg_addr_t waddr, input word_t wdata);
	if (exp_reg.size() == 0) begin
		$display("unexpected write-back on pipe %s to r%0d with no result pending", sfx, waddr);
		other_errors++;
	end else begin
		compare_addr({"wb_waddr_", sfx}, waddr, exp_reg.pop_front());
		compare_word({"wb_wdata_", sfx}, wdata, exp_val.pop_front());
	end
endtask

// Alpha is older than beta within a cycle
always @(negedge clk) begin
	if (arst_n) begin
		if (wb_we_a) begin
			match_write_back("a", wb_waddr_a, wb_wdata_a);
		end
		if (wb_we_b) begin
			match_write_back("b", wb_waddr_b, wb_wdata_b);
		end
	end
end

task automatic start_program();
	@(posedge clk);
	#1;
	reset_req = 1'b1;
	for (int i = 0; i < MEM_WORDS; i++) begin
		imem[i[7:0]] = (i < prog.size()) ? prog[i] : '0;
	end
	exp_reg.delete();
	exp_val.delete();
	for (int i = 0; i < 32; i++) begin
		model_rf[i[4:0]] = '0;
	end
	foreach (prog[i]) begin
		model_exec(prog[i]);
	end
	@(posedge clk);
	#1;
	reset_req = 1'b0;
	wait (arst_n);
endtask

task automatic drain_results(input string test_name);
	int cycles;
	cycles = 0;
	while (exp_reg.size() != 0 && cycles < DRAIN_LIMIT) begin
		@(posedge clk);
		cycles++;
	end
	if (exp_reg.size() != 0) begin
		$display("%s: %0d expected write-backs never appeared", test_name, exp_reg.size());
		other_errors++;
	end
	// Quiet period catches stray writes
	repeat (TAIL_CYCLES) @(posedge clk);
endtask

task automatic check_reset_state();
	prog.delete();
	prog.push_back(encode_itype(OPC_ADDIU, 1, 0, 16'd1));
	prog.push_back(encode_itype(OPC_ADDIU, 2, 0, 16'd2));
	start_program();
	compare_word("inst_addr", inst_addr, RESET_PC);
	compare_flag("wb_we_a", wb_we_a, 1'b0);
	compare_flag("wb_we_b", wb_we_b, 1'b0);
	@(negedge clk);
	compare_flag("wb_we_a", wb_we_a, 1'b0);
	compare_flag("wb_we_b", wb_we_b, 1'b0);
	drain_results("reset state");
endtask

task automatic run_dual_pair();
	prog.delete();
	prog.push_back(encode_itype(OPC_ADDIU, 3, 0, 16'h1234));
	prog.push_back(encode_itype(OPC_LUI, 4, 0, 16'habcd));
	start_program();
	@(negedge clk);
	compare_word("inst_addr", inst_addr, 32'd8);
	@(negedge clk);
	compare_flag("wb_we_a", wb_we_a, 1'b1);
	compare_flag("wb_we_b", wb_we_b, 1'b1);
	compare_addr("wb_waddr_a", wb_waddr_a, 5'd3);
	compare_addr("wb_waddr_b", wb_waddr_b, 5'd4);
	compare_word("wb_wdata_a", wb_wdata_a, 32'h0000_1234);
	compare_word("wb_wdata_b", wb_wdata_b, 32'habcd_0000);
	drain_results("dual issue");
endtask

task automatic run_held_back_pair();
	prog.delete();
	prog.push_back(encode_itype(OPC_ADDIU, 1, 0, 16'd5));
	prog.push_back(encode_rtype(FUNCT_ADDU, 2, 1, 1));
	start_program();
	@(negedge clk);
	compare_word("inst_addr", inst_addr, 32'd4);
	@(negedge clk);
	compare_flag("wb_we_a", wb_we_a, 1'b1);
	compare_flag("wb_we_b", wb_we_b, 1'b0);
	compare_word("wb_wdata_a", wb_wdata_a, 32'd5);
	@(negedge clk);
	compare_flag("wb_we_a", wb_we_a, 1'b1);
	compare_addr("wb_waddr_a", wb_waddr_a, 5'd2);
	compare_word("wb_wdata_a", wb_wdata_a, 32'd10);
	drain_results("held back");
endtask

// EX and WB forwarding and dropped r0 writes
task automatic run_forwarding_chain();
	prog.delete();
	prog.push_back(encode_itype(OPC_ADDIU, 1, 0, 16'd3));
	prog.push_back(encode_itype(OPC_ADDIU, 2, 0, 16'd4));
	prog.push_back(encode_rtype(FUNCT_ADDU, 3, 1, 2));
	prog.push_back(encode_rtype(FUNCT_SUBU, 4, 2, 1));
	prog.push_back(encode_itype(OPC_ADDIU, 0, 3, 16'd9));
	prog.push_back(encode_rtype(FUNCT_OR, 5, 4, 1));
	prog.push_back(encode_rtype(FUNCT_ADDU, 6, 0, 5));
	prog.push_back(encode_rtype(FUNCT_XOR, 7, 3, 0));
	prog.push_back(encode_rtype(FUNCT_ADDU, 0, 6, 7));
	prog.push_back(encode_rtype(FUNCT_SLT, 1, 4, 7));
	prog.push_back(encode_rtype(FUNCT_AND, 2, 6, 0));
	start_program();
	drain_results("forwarding");
endtask

task automatic sweep_alu_ops();
	word_t imm;
	prog.delete();
	for (int round = 0; round < 4; round++) begin
		for (int k = 0; k < 6; k++) begin
			load_const(1, rand_bits(32));
			load_const(2, rand_bits(32));
			prog.push_back(encode_rtype(funct_code(k), 3, 1, 2));
		end
		imm = rand_bits(16);
		prog.push_back(encode_itype(OPC_ADDIU, 4, 1, imm[15:0]));
		imm = rand_bits(16);
		prog.push_back(encode_itype(OPC_LUI, 5, 0, imm[15:0]));
	end
	start_program();
	drain_results("alu ops");
endtask

// Only eight registers so hazards are frequent
task automatic run_random_program();
	int    sel;
	word_t imm;
	prog.delete();
	// Seed r1 to r7 before the mix reads them
	for (int r = 1; r < 8; r++) begin
		load_const(r, rand_bits(32));
	end
	for (int i = 0; i < 200; i++) begin
		sel = rand_bits(3);
		imm = rand_bits(16);
		if (sel < 6) begin
			prog.push_back(encode_rtype(funct_code(sel), rand_bits(3), rand_bits(3),
				rand_bits(3)));
		end else if (sel == 6) begin
			prog.push_back(encode_itype(OPC_ADDIU, rand_bits(3), rand_bits(3), imm[15:0]));
		end else begin
			prog.push_back(encode_itype(OPC_LUI, rand_bits(3), 0, imm[15:0]));
		end
	end
	start_program();
	drain_results("random program");
endtask

initial begin
	reset_req = 1'b0;
	for (int i = 0; i < MEM_WORDS; i++) begin
		imem[i[7:0]] = '0;
	end
	check_reset_state();
	run_dual_pair();
	run_held_back_pair();
	run_forwarding_chain();
	sweep_alu_ops();
	run_random_program();
	$display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
	if (mismatches + other_errors == 0) begin
		$display("Done: no errors");
	end else begin
		$display("Done: errors found");
	end
	$finish;
end

initial begin
	#(WATCHDOG_NS);
	$display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
	$display("Done: errors found");
	$finish;
end

endmodule
